// File: design/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

    localparam int XLEN           = 32;
    localparam int INSTR_WIDTH    = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OPCODE_WIDTH   = 7;
    localparam int FUNCT3_WIDTH   = 3;
    localparam int FUNCT7_WIDTH   = 7;

    // field positions inside the instruction word
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // raw immediate field widths before extension
    localparam int IMM_I_WIDTH = 12;
    localparam int IMM_B_WIDTH = 13;
    localparam int IMM_U_WIDTH = 20;
    localparam int IMM_J_WIDTH = 21;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    localparam logic [FUNCT3_WIDTH-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_WIDTH-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_WIDTH-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_WIDTH-1:0] F3_AND     = 3'b111;

    localparam logic [FUNCT3_WIDTH-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BGEU = 3'b111;
    localparam logic [FUNCT3_WIDTH-1:0] F3_JALR = 3'b000;

    localparam logic [FUNCT7_WIDTH-1:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [FUNCT7_WIDTH-1:0] FUNCT7_ALT  = 7'b0100000; // sub, sra, srai

endpackage

`default_nettype wire

// File: design/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

    localparam int ALU_CODE_WIDTH   = 4;
    localparam int SHIFT_CODE_WIDTH = 2;
    localparam int CMP_CODE_WIDTH   = 3;
    localparam int IMM_FMT_WIDTH    = 3;

    typedef enum logic [ALU_CODE_WIDTH-1:0] {
        alu_none = 4'd0,
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7
    } alu_op_e;

    typedef enum logic [SHIFT_CODE_WIDTH-1:0] {
        shift_none = 2'd0,
        shift_sll  = 2'd1,
        shift_srl  = 2'd2,
        shift_sra  = 2'd3
    } shift_op_e;

    typedef enum logic [CMP_CODE_WIDTH-1:0] {
        cmp_none = 3'd0,
        cmp_beq  = 3'd1,
        cmp_bne  = 3'd2,
        cmp_blt  = 3'd3,
        cmp_bge  = 3'd4,
        cmp_bltu = 3'd5,
        cmp_bgeu = 3'd6
    } cmp_op_e;

    typedef enum logic [IMM_FMT_WIDTH-1:0] {
        imm_none = 3'd0,
        imm_i    = 3'd1,
        imm_b    = 3'd2,
        imm_u    = 3'd3,
        imm_j    = 3'd4
    } imm_fmt_e;

endpackage

`default_nettype wire

// File: design/decode_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_ctrl_if import decode_ctrl_pkg::*; ();

    logic      alu_op;
    logic      shift_op;
    logic      comparator_op;
    logic      rs1_use;
    logic      rs2_use;
    logic      rd_use;
    logic      imm_use;
    logic      is_branch;
    alu_op_e   alu_control;
    shift_op_e shift_control;
    cmp_op_e   comparator_control;

    modport decoder (
        output alu_op, shift_op, comparator_op,
        output rs1_use, rs2_use, rd_use, imm_use, is_branch,
        output alu_control, shift_control, comparator_control
    );

    modport stage (
        input alu_op, shift_op, comparator_op,
        input rs1_use, rs2_use, rd_use, imm_use, is_branch,
        input alu_control, shift_control, comparator_control
    );

endinterface

`default_nettype wire

// File: design/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder
    import rv32i_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  logic [INSTR_WIDTH-1:0] instr,
    decode_ctrl_if.decoder         ctrl,
    output imm_fmt_e               imm_fmt,
    output logic                   imm_sign_ext
);

    opcode_e                 opcode;
    logic [FUNCT3_WIDTH-1:0] funct3;
    logic [FUNCT7_WIDTH-1:0] funct7;

    alu_op_e   alu_code;
    shift_op_e shift_code;
    cmp_op_e   cmp_code;
    logic      rs1_use;
    logic      rs2_use;
    logic      rd_use;
    logic      is_branch;

    assign opcode = opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
    assign funct3 = instr[FUNCT3_LSB +: FUNCT3_WIDTH];
    assign funct7 = instr[FUNCT7_LSB +: FUNCT7_WIDTH];

    always_comb
    begin
        alu_code     = alu_none;
        shift_code   = shift_none;
        cmp_code     = cmp_none;
        rs1_use      = 1'b0;
        rs2_use      = 1'b0;
        rd_use       = 1'b0;
        is_branch    = 1'b0;
        imm_fmt      = imm_none;
        imm_sign_ext = 1'b0;
        case (opcode)
            op_reg:
            begin
                if (funct7 == FUNCT7_BASE)
                begin
                    case (funct3)
                        F3_ADD_SUB: alu_code   = alu_add;
                        F3_SLL:     shift_code = shift_sll;
                        F3_SLT:     alu_code   = alu_slt;
                        F3_SLTU:    alu_code   = alu_sltu;
                        F3_XOR:     alu_code   = alu_xor;
                        F3_SRL_SRA: shift_code = shift_srl;
                        F3_OR:      alu_code   = alu_or;
                        F3_AND:     alu_code   = alu_and;
                        default:    alu_code   = alu_none;
                    endcase
                end
                else if (funct7 == FUNCT7_ALT)
                begin
                    if (funct3 == F3_ADD_SUB)
                        alu_code = alu_sub;
                    else if (funct3 == F3_SRL_SRA)
                        shift_code = shift_sra;
                end
                if (alu_code != alu_none || shift_code != shift_none)
                begin
                    rs1_use = 1'b1;
                    rs2_use = 1'b1;
                    rd_use  = 1'b1;
                end
            end
            op_imm:
            begin
                case (funct3)
                    F3_ADD_SUB: alu_code = alu_add;
                    F3_SLT:     alu_code = alu_slt;
                    F3_SLTU:    alu_code = alu_sltu;
                    F3_XOR:     alu_code = alu_xor;
                    F3_OR:      alu_code = alu_or;
                    F3_AND:     alu_code = alu_and;
                    F3_SLL:     shift_code = (funct7 == FUNCT7_BASE) ? shift_sll : shift_none;
                    F3_SRL_SRA:
                    begin
                        if (funct7 == FUNCT7_BASE)
                            shift_code = shift_srl;
                        else if (funct7 == FUNCT7_ALT)
                            shift_code = shift_sra; // funct7 bit stays in the imm
                    end
                    default:    alu_code = alu_none;
                endcase
                if (alu_code != alu_none || shift_code != shift_none)
                begin
                    rs1_use      = 1'b1;
                    rd_use       = 1'b1;
                    imm_fmt      = imm_i;
                    imm_sign_ext = (shift_code == shift_none); // shamt is unsigned
                end
            end
            op_lui, op_auipc:
            begin
                alu_code     = alu_add;
                rd_use       = 1'b1;
                imm_fmt      = imm_u;
                imm_sign_ext = 1'b1;
            end
            op_branch:
            begin
                case (funct3)
                    F3_BEQ:  cmp_code = cmp_beq;
                    F3_BNE:  cmp_code = cmp_bne;
                    F3_BLT:  cmp_code = cmp_blt;
                    F3_BGE:  cmp_code = cmp_bge;
                    F3_BLTU: cmp_code = cmp_bltu;
                    F3_BGEU: cmp_code = cmp_bgeu;
                    default: cmp_code = cmp_none;
                endcase
                if (cmp_code != cmp_none)
                begin
                    alu_code     = alu_add; // target address
                    rs1_use      = 1'b1;
                    rs2_use      = 1'b1;
                    imm_fmt      = imm_b;
                    imm_sign_ext = 1'b1;
                    is_branch    = 1'b1;
                end
            end
            op_jal:
            begin
                alu_code     = alu_add;
                rd_use       = 1'b1;
                imm_fmt      = imm_j;
                imm_sign_ext = 1'b1;
                is_branch    = 1'b1;
            end
            op_jalr:
            begin
                if (funct3 == F3_JALR)
                begin
                    alu_code     = alu_add;
                    rs1_use      = 1'b1;
                    rd_use       = 1'b1;
                    imm_fmt      = imm_i;
                    imm_sign_ext = 1'b1;
                    is_branch    = 1'b1;
                end
            end
            default:
            begin
                alu_code = alu_none; // nothing set for loads, stores and system
            end
        endcase
    end

    // unit flags follow from the codes
    assign ctrl.alu_op             = (alu_code != alu_none);
    assign ctrl.shift_op           = (shift_code != shift_none);
    assign ctrl.comparator_op      = (cmp_code != cmp_none);
    assign ctrl.imm_use            = (imm_fmt != imm_none);
    assign ctrl.alu_control        = alu_code;
    assign ctrl.shift_control      = shift_code;
    assign ctrl.comparator_control = cmp_code;
    assign ctrl.rs1_use            = rs1_use;
    assign ctrl.rs2_use            = rs2_use;
    assign ctrl.rd_use             = rd_use;
    assign ctrl.is_branch          = is_branch;

endmodule

`default_nettype wire

// File: design/imm_generator.sv
`timescale 1ns/1ps
`default_nettype none

module imm_generator
    import rv32i_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  logic [INSTR_WIDTH-1:0] instr,
    input  imm_fmt_e               imm_fmt,
    input  logic                   imm_sign_ext,
    output logic [XLEN-1:0]        imm
);

    logic [IMM_I_WIDTH-1:0] imm_i_field;
    logic [IMM_B_WIDTH-1:0] imm_b_field;
    logic [IMM_U_WIDTH-1:0] imm_u_field;
    logic [IMM_J_WIDTH-1:0] imm_j_field;

    assign imm_i_field = instr[31:20];
    assign imm_b_field = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}; // lsb always 0
    assign imm_u_field = instr[31:12];
    assign imm_j_field = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        case (imm_fmt)
            imm_i:
                imm = {{(XLEN-IMM_I_WIDTH){imm_sign_ext & imm_i_field[IMM_I_WIDTH-1]}},
                       imm_i_field};
            imm_b:
                imm = {{(XLEN-IMM_B_WIDTH){imm_sign_ext & imm_b_field[IMM_B_WIDTH-1]}},
                       imm_b_field};
            imm_u:
                imm = {imm_u_field, {(XLEN-IMM_U_WIDTH){1'b0}}}; // low 12 bits zero
            imm_j:
                imm = {{(XLEN-IMM_J_WIDTH){imm_sign_ext & imm_j_field[IMM_J_WIDTH-1]}},
                       imm_j_field};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/decode_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg
    import rv32i_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [INSTR_WIDTH-1:0]    instr,
    decode_ctrl_if.stage              ctrl,
    input  logic [XLEN-1:0]           imm_in,
    output logic                      dec_valid,
    output logic                      alu_op,
    output logic                      shift_op,
    output logic                      comparator_op,
    output logic                      rs1_use,
    output logic                      rs2_use,
    output logic                      rd_use,
    output logic                      imm_use,
    output logic                      is_branch,
    output alu_op_e                   alu_control,
    output shift_op_e                 shift_control,
    output cmp_op_e                   comparator_control,
    output logic [XLEN-1:0]           imm,
    output logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dec_valid          <= 1'b0;
            alu_op             <= 1'b0;
            shift_op           <= 1'b0;
            comparator_op      <= 1'b0;
            rs1_use            <= 1'b0;
            rs2_use            <= 1'b0;
            rd_use             <= 1'b0;
            imm_use            <= 1'b0;
            is_branch          <= 1'b0;
            alu_control        <= alu_none;
            shift_control      <= shift_none;
            comparator_control <= cmp_none;
        end
        else
        begin
            dec_valid <= instr_valid; // drops for one cycle on a bubble
            if (instr_valid)
            begin
                alu_op             <= ctrl.alu_op;
                shift_op           <= ctrl.shift_op;
                comparator_op      <= ctrl.comparator_op;
                rs1_use            <= ctrl.rs1_use;
                rs2_use            <= ctrl.rs2_use;
                rd_use             <= ctrl.rd_use;
                imm_use            <= ctrl.imm_use;
                is_branch          <= ctrl.is_branch;
                alu_control        <= ctrl.alu_control;
                shift_control      <= ctrl.shift_control;
                comparator_control <= ctrl.comparator_control;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            imm      <= imm_in;
            rs1_addr <= instr[RS1_LSB +: REG_ADDR_WIDTH];
            rs2_addr <= instr[RS2_LSB +: REG_ADDR_WIDTH];
            rd_addr  <= instr[RD_LSB +: REG_ADDR_WIDTH];
        end
    end

endmodule

`default_nettype wire

// File: design/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit
    import rv32i_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [INSTR_WIDTH-1:0]    instr,
    output logic                      dec_valid,
    output logic                      alu_op,
    output logic                      shift_op,
    output logic                      comparator_op,
    output logic                      rs1_use,
    output logic                      rs2_use,
    output logic                      rd_use,
    output logic                      imm_use,
    output logic                      is_branch,
    output alu_op_e                   alu_control,
    output shift_op_e                 shift_control,
    output cmp_op_e                   comparator_control,
    output logic [XLEN-1:0]           imm,
    output logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr
);

    imm_fmt_e          imm_fmt;
    logic              imm_sign_ext;
    logic [XLEN-1:0]   imm_comb; // before the stage register

    decode_ctrl_if ctrl_bus ();

    opcode_decoder u_opcode_decoder (
        .instr        (instr),
        .ctrl         (ctrl_bus.decoder),
        .imm_fmt      (imm_fmt),
        .imm_sign_ext (imm_sign_ext)
    );

    imm_generator u_imm_generator (
        .instr        (instr),
        .imm_fmt      (imm_fmt),
        .imm_sign_ext (imm_sign_ext),
        .imm          (imm_comb)
    );

    decode_stage_reg u_decode_stage_reg (
        .clk                (clk),
        .reset              (reset),
        .instr_valid        (instr_valid),
        .instr              (instr),
        .ctrl               (ctrl_bus.stage),
        .imm_in             (imm_comb),
        .dec_valid          (dec_valid),
        .alu_op             (alu_op),
        .shift_op           (shift_op),
        .comparator_op      (comparator_op),
        .rs1_use            (rs1_use),
        .rs2_use            (rs2_use),
        .rd_use             (rd_use),
        .imm_use            (imm_use),
        .is_branch          (is_branch),
        .alu_control        (alu_control),
        .shift_control      (shift_control),
        .comparator_control (comparator_control),
        .imm                (imm),
        .rs1_addr           (rs1_addr),
        .rs2_addr           (rs2_addr),
        .rd_addr            (rd_addr)
    );

endmodule

`default_nettype wire

// File: verif/decode_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit_tb;

    localparam int WAIT_LIMIT = 20; // cycles before a wait gives up

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;

    logic        dec_valid;
    logic        alu_op;
    logic        shift_op;
    logic        comparator_op;
    logic        rs1_use;
    logic        rs2_use;
    logic        rd_use;
    logic        imm_use;
    logic        is_branch;
    logic [3:0]  alu_control;
    logic [1:0]  shift_control;
    logic [2:0]  comparator_control;
    logic [31:0] imm;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;

    // expected values per stimulus line
    logic [31:0] instr_q[$];
    logic [31:0] flags_q[$];
    logic [31:0] alu_q[$];
    logic [31:0] shift_q[$];
    logic [31:0] cmp_q[$];
    logic [31:0] imm_q[$];
    logic [31:0] rs1_q[$];
    logic [31:0] rs2_q[$];
    logic [31:0] rd_q[$];

    logic [31:0] lfsr_state;
    int          cycles;

    decode_unit u_dut (
        .clk                (clk),
        .reset              (reset),
        .instr_valid        (instr_valid),
        .instr              (instr),
        .dec_valid          (dec_valid),
        .alu_op             (alu_op),
        .shift_op           (shift_op),
        .comparator_op      (comparator_op),
        .rs1_use            (rs1_use),
        .rs2_use            (rs2_use),
        .rd_use             (rd_use),
        .imm_use            (imm_use),
        .is_branch          (is_branch),
        .alu_control        (alu_control),
        .shift_control      (shift_control),
        .comparator_control (comparator_control),
        .imm                (imm),
        .rs1_addr           (rs1_addr),
        .rs2_addr           (rs2_addr),
        .rd_addr            (rd_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic string flag_name(input int bit_idx);
        case (bit_idx)
            7: return "alu_op";
            6: return "shift_op";
            5: return "comparator_op";
            4: return "rs1_use";
            3: return "rs2_use";
            2: return "rd_use";
            1: return "imm_use";
            default: return "is_branch";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "%s", what);
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        logic [31:0] f[9];
        fd = $fopen("verif/decode_stim.txt", "r");
        if (fd == 0)
            stop_on_error("could not open verif/decode_stim.txt");
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == 8'h23)
                continue; // blank or comment
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n != 9)
                stop_on_error({"malformed stimulus line: ", line});
            instr_q.push_back(f[0]);
            flags_q.push_back(f[1]);
            alu_q.push_back(f[2]);
            shift_q.push_back(f[3]);
            cmp_q.push_back(f[4]);
            imm_q.push_back(f[5]);
            rs1_q.push_back(f[6]);
            rs2_q.push_back(f[7]);
            rd_q.push_back(f[8]);
        end
        $fclose(fd);
        if (instr_q.size() == 0)
            stop_on_error("stimulus file holds no instructions");
    endtask

    task automatic check_reset_state();
        check_value("dec_valid", 32'(dec_valid), 32'd0);
        check_value("flags", 32'({alu_op, shift_op, comparator_op, rs1_use, rs2_use,
                                  rd_use, imm_use, is_branch}), 32'd0);
        check_value("alu_control", 32'(alu_control), 32'd0);
        check_value("shift_control", 32'(shift_control), 32'd0);
        check_value("comparator_control", 32'(comparator_control), 32'd0);
    endtask

    task automatic check_outputs(input int idx, input logic exp_valid);
        logic [7:0] got_flags;
        got_flags = {alu_op, shift_op, comparator_op, rs1_use, rs2_use,
                     rd_use, imm_use, is_branch};
        check_value("dec_valid", 32'(dec_valid), 32'(exp_valid));
        for (int b = 7; b >= 0; b--)
            check_value(flag_name(b), 32'(got_flags[b]), 32'(flags_q[idx][b]));
        check_value("alu_control", 32'(alu_control), alu_q[idx]);
        check_value("shift_control", 32'(shift_control), shift_q[idx]);
        check_value("comparator_control", 32'(comparator_control), cmp_q[idx]);
        check_value("imm", imm, imm_q[idx]);
        check_value("rs1_addr", 32'(rs1_addr), rs1_q[idx]);
        check_value("rs2_addr", 32'(rs2_addr), rs2_q[idx]);
        check_value("rd_addr", 32'(rd_addr), rd_q[idx]);
    endtask

    // counts falling edges until dec_valid shows up
    task automatic wait_for_valid(input int idx, output int count);
        count = 0;
        do
        begin
            @(negedge clk);
            count++;
        end
        while (!dec_valid && count < WAIT_LIMIT);
        if (!dec_valid)
            stop_on_error($sformatf("timed out waiting for dec_valid on entry %0d", idx));
    endtask

    initial
    begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 32'h1a53;
        cycles      = 0;
        load_stim();

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        reset = 1'b0;
        @(negedge clk);
        check_reset_state(); // nothing accepted yet

        for (int idx = 0; idx < instr_q.size(); idx++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            if (lfsr_state[0])
            begin
                instr_valid = 1'b0;
                instr       = ~instr_q[idx]; // must not be captured
                @(negedge clk);
                if (idx == 0)
                    check_reset_state();
                else
                    check_outputs(idx - 1, 1'b0);
            end
            instr_valid = 1'b1;
            instr       = instr_q[idx];
            wait_for_valid(idx, cycles);
            check_value("latency", 32'(cycles), 32'd1);
            check_outputs(idx, 1'b1);
        end
        instr_valid = 1'b0;

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
design/rv32i_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/decode_ctrl_if.sv
design/opcode_decoder.sv
design/imm_generator.sv
design/decode_stage_reg.sv
design/decode_unit.sv
verif/decode_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the decode unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module decode_unit_tb -o decode_unit_sim

# the simulator exits non-zero on a fatal check, so keep going to the log search
./obj_dir/decode_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: verif/decode_stim.txt
# instr flags(alu,shift,cmp,rs1,rs2,rd,imm,br) alu shift cmp imm rs1 rs2 rd
# all values hex
002081B3 9C 1 0 0 00000000 01 02 03
402081B3 9C 2 0 0 00000000 01 02 03
002091B3 5C 0 1 0 00000000 01 02 03
0020A1B3 9C 3 0 0 00000000 01 02 03
0020B1B3 9C 4 0 0 00000000 01 02 03
0020C1B3 9C 5 0 0 00000000 01 02 03
0020D1B3 5C 0 2 0 00000000 01 02 03
4020D1B3 5C 0 3 0 00000000 01 02 03
0020E1B3 9C 6 0 0 00000000 01 02 03
0020F1B3 9C 7 0 0 00000000 01 02 03
01DF0FB3 9C 1 0 0 00000000 1E 1D 1F
FFF30293 96 1 0 0 FFFFFFFF 06 1F 05
06430293 96 1 0 0 00000064 06 04 05
80032293 96 3 0 0 FFFFF800 06 00 05
7FF33293 96 4 0 0 000007FF 06 1F 05
AAA34293 96 5 0 0 FFFFFAAA 06 0A 05
12336293 96 6 0 0 00000123 06 03 05
F0F37293 96 7 0 0 FFFFFF0F 06 0F 05
01F31293 56 0 1 0 0000001F 06 1F 05
00735293 56 0 2 0 00000007 06 07 05
40735293 56 0 3 0 00000407 06 07 05
41F35293 56 0 3 0 0000041F 06 1F 05
123453B7 86 1 0 0 12345000 08 03 07
FFFFF397 86 1 0 0 FFFFF000 1F 1F 07
00208463 BB 1 0 1 00000008 01 02 08
FE209CE3 BB 1 0 2 FFFFFFF8 01 02 19
0020C0E3 BB 1 0 3 00000800 01 02 01
8020D063 BB 1 0 4 FFFFF000 01 02 00
7E20EFE3 BB 1 0 5 00000FFE 01 02 1F
0020F863 BB 1 0 6 00000010 01 02 10
001000EF 87 1 0 0 00000800 00 01 01
FFFFF06F 87 1 0 0 FFFFFFFE 1F 1F 00
344120EF 87 1 0 0 00012344 02 04 01
FFC280E7 97 1 0 0 FFFFFFFC 05 1C 01
0040A183 00 0 0 0 00000000 01 04 03
0020A423 00 0 0 0 00000000 01 02 08
022081B3 00 0 0 0 00000000 01 02 03
402091B3 00 0 0 0 00000000 01 02 03
41F31293 00 0 0 0 00000000 06 1F 05
00000073 00 0 0 0 00000000 00 00 00
0020A463 00 0 0 0 00000000 01 02 08
FFC290E7 00 0 0 0 00000000 05 1C 01
00000000 00 0 0 0 00000000 00 00 00
